// ==== common/lbd_config.svh ====
`ifndef LBD_CONFIG_SVH
`define LBD_CONFIG_SVH

// fetch geometry
`define LBD_LANES      4   // lanes per fetch bundle
`define LBD_ADDR_W     16  // bits per lane address

// loop address table
`define LBD_LAT_DEPTH  4

// instruction buffer capacity, also the unroll budget
`define LBD_BUF_SLOTS  64

`endif

// ==== common/fetch_pkg.sv ====
`include "lbd_config.svh"

package fetch_pkg;

   // one instruction address inside a fetch bundle
   typedef logic [`LBD_ADDR_W-1:0] lane_addr_t;

   // per-lane valid bits, msb is lane 0
   typedef logic [`LBD_LANES-1:0] lane_mask_t;

   // backward branch flags, same lane order as the mask
   typedef logic [`LBD_LANES-1:0] bck_flags_t;

endpackage

// ==== common/lbd_pkg.sv ====
`include "lbd_config.svh"

package lbd_pkg;

   // reported front-end state
   typedef enum logic [1:0] {
      IDLE     = 2'b00,
      TRAIN    = 2'b01,
      DISPATCH = 2'b10
   } lbd_state_t;

   // one trained loop, 47 bits
   typedef struct packed {
      logic                  valid;
      fetch_pkg::lane_addr_t start_addr;        // first instruction of the body
      fetch_pkg::lane_addr_t fallthrough_addr;  // branch address plus one
      logic [6:0]            num_insts;         // body length, saturates at 127
      logic [6:0]            max_unroll;        // passes that fit the buffer
   } lat_entry_t;

endpackage

// ==== trainer/back_branch_trainer.sv ====
`timescale 1ns/10ps
`include "lbd_config.svh"

module back_branch_trainer (
   input  logic                               clk,
   input  logic                               rst,
   input  logic [`LBD_LANES*`LBD_ADDR_W-1:0]  pc_in,
   input  fetch_pkg::bck_flags_t              bck_lp_bus_in,
   input  logic                               mis_pred_in,
   input  logic                               disp_active,
   output logic                               train_busy,
   output logic                               train_wr,
   output lbd_pkg::lat_entry_t                train_entry
);

   typedef enum logic [1:0] {
      TR_IDLE  = 2'b00,
      TR_AWAIT = 2'b01,  // waiting for the loop start bundle
      TR_COUNT = 2'b10
   } tr_state_t;

   tr_state_t             state_q;
   fetch_pkg::lane_addr_t fallthru_q;
   fetch_pkg::lane_addr_t start_q;
   fetch_pkg::lane_addr_t branch_next;
   fetch_pkg::lane_addr_t end_addr;
   logic [6:0]            count_q;
   logic [6:0]            count_sum;
   logic [7:0]            count_wide;
   logic [2:0]            body_lanes;
   logic                  end_found;
   logic                  start_train;

   assign start_train = (state_q == TR_IDLE) && !disp_active && (|bck_lp_bus_in);
   assign train_busy  = (state_q != TR_IDLE);
   assign end_addr    = fallthru_q - 1'b1;  // address of the branch itself

   // first flagged lane from lane 0 gives the fall-through
   always_comb begin
      branch_next = '0;
      for (int i = `LBD_LANES-1; i >= 0; i--) begin
         if (bck_lp_bus_in[`LBD_LANES-1-i]) begin
            branch_next = pc_in[(`LBD_LANES-1-i)*`LBD_ADDR_W +: `LBD_ADDR_W] + 1'b1;
         end
      end
   end

   // lanes of this bundle that belong to the body
   always_comb begin
      end_found  = 1'b0;
      body_lanes = 3'(`LBD_LANES);
      for (int i = `LBD_LANES-1; i >= 0; i--) begin
         if (pc_in[(`LBD_LANES-1-i)*`LBD_ADDR_W +: `LBD_ADDR_W] == end_addr) begin
            end_found  = 1'b1;
            body_lanes = 3'(i + 1);
         end
      end
   end

   // count restarts on the start bundle
   assign count_wide = ((state_q == TR_AWAIT) ? 8'd0 : {1'b0, count_q}) + body_lanes;
   assign count_sum  = count_wide[7] ? 7'h7f : count_wide[6:0];

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state_q  <= TR_IDLE;
         train_wr <= 1'b0;
      end else begin
         train_wr <= 1'b0;
         case (state_q)
            TR_IDLE: begin
               if (start_train) begin
                  state_q <= TR_AWAIT;
               end
            end
            TR_AWAIT, TR_COUNT: begin
               if (mis_pred_in || disp_active) begin
                  state_q <= TR_IDLE;  // abandoned, nothing written
               end else if (end_found) begin
                  state_q  <= TR_IDLE;
                  train_wr <= 1'b1;
               end else begin
                  state_q <= TR_COUNT;
               end
            end
            default: state_q <= TR_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (start_train) begin
         fallthru_q <= branch_next;
      end
      if (state_q == TR_AWAIT) begin
         start_q <= pc_in[(`LBD_LANES-1)*`LBD_ADDR_W +: `LBD_ADDR_W];
      end
      if (state_q != TR_IDLE) begin
         count_q <= count_sum;
      end
   end

   // entry is presented while train_wr is high
   always_comb begin
      train_entry.valid            = 1'b1;
      train_entry.start_addr       = start_q;
      train_entry.fallthrough_addr = fallthru_q;
      train_entry.num_insts        = count_q;
      if (count_q == 7'd0 || count_q > 7'(`LBD_BUF_SLOTS)) begin
         train_entry.max_unroll = 7'd0;  // body does not fit
      end else begin
         train_entry.max_unroll = 7'(`LBD_BUF_SLOTS / count_q);
      end
   end

   // a write always needs a fresh start bundle first
   a_wr_single: assert property (@(posedge clk) disable iff (rst)
      train_wr |=> !train_wr);

endmodule

// ==== verilog/loop_addr_table.sv ====
`timescale 1ns/10ps
`include "lbd_config.svh"

module loop_addr_table (
   input  logic                               clk,
   input  logic                               rst,
   input  logic [`LBD_LANES*`LBD_ADDR_W-1:0]  pc_in,
   input  logic                               train_wr,
   input  lbd_pkg::lat_entry_t                train_entry,
   output logic                               lat_hit,
   output lbd_pkg::lat_entry_t                hit_entry
);

   lbd_pkg::lat_entry_t                  lat_q [`LBD_LAT_DEPTH];
   logic [$clog2(`LBD_LAT_DEPTH)-1:0]   wr_ptr_q;  // round-robin victim
   fetch_pkg::lane_addr_t               lane0_addr;

   assign lane0_addr = pc_in[(`LBD_LANES-1)*`LBD_ADDR_W +: `LBD_ADDR_W];

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         for (int i = 0; i < `LBD_LAT_DEPTH; i++) begin
            lat_q[i] <= '0;
         end
         wr_ptr_q <= '0;
      end else if (train_wr) begin
         lat_q[wr_ptr_q] <= train_entry;
         wr_ptr_q        <= wr_ptr_q + 1'b1;  // wraps after the last entry
      end
   end

   // parallel compare, scan down so the lowest index wins
   always_comb begin
      lat_hit   = 1'b0;
      hit_entry = '0;
      for (int i = `LBD_LAT_DEPTH-1; i >= 0; i--) begin
         if (lat_q[i].valid && (lat_q[i].start_addr == lane0_addr)) begin
            lat_hit   = 1'b1;
            hit_entry = lat_q[i];
         end
      end
   end

   // the trainer must hand over a valid entry
   a_wr_valid: assert property (@(posedge clk) disable iff (rst)
      train_wr |=> lat_q[$past(wr_ptr_q)].valid);

endmodule

// ==== dispatch/unroll_dispatcher.sv ====
`timescale 1ns/10ps
`include "lbd_config.svh"

module unroll_dispatcher (
   input  logic                               clk,
   input  logic                               rst,
   input  logic [`LBD_LANES*`LBD_ADDR_W-1:0]  pc_in,
   input  logic                               mis_pred_in,
   input  logic                               lat_hit,
   input  lbd_pkg::lat_entry_t                hit_entry,
   input  logic                               train_busy,
   output logic                               disp_active,
   output logic                               loop_strt,
   output fetch_pkg::lane_mask_t              inst_valid,
   output logic                               fnsh_unrll,
   output logic                               stll_ftch,
   output lbd_pkg::lbd_state_t                lbd_state
);

   logic                  dispatching_q;
   fetch_pkg::lane_addr_t fallthru_q;
   fetch_pkg::lane_addr_t end_addr;
   logic [6:0]            remain_q;     // unroll passes left
   logic [6:0]            stall_cnt_q;  // instructions sent to the buffer
   logic [7:0]            stall_sum;
   logic [2:0]            valid_lanes;
   fetch_pkg::lane_mask_t lane_mask;
   logic                  end_found;

   assign disp_active = dispatching_q;
   assign loop_strt   = lat_hit && !dispatching_q;
   assign end_addr    = fallthru_q - 1'b1;

   always_comb begin
      if (dispatching_q) begin
         lbd_state = lbd_pkg::DISPATCH;
      end else if (train_busy) begin
         lbd_state = lbd_pkg::TRAIN;
      end else begin
         lbd_state = lbd_pkg::IDLE;
      end
   end

   // end lane search, first match from lane 0
   always_comb begin
      end_found   = 1'b0;
      valid_lanes = 3'(`LBD_LANES);
      lane_mask   = '1;
      for (int i = `LBD_LANES-1; i >= 0; i--) begin
         if (pc_in[(`LBD_LANES-1-i)*`LBD_ADDR_W +: `LBD_ADDR_W] == end_addr) begin
            end_found   = 1'b1;
            valid_lanes = 3'(i + 1);
            lane_mask   = {`LBD_LANES{1'b1}} << (`LBD_LANES-1-i);  // drop lanes past the end
         end
      end
   end

   assign inst_valid = dispatching_q ? lane_mask : '1;
   assign fnsh_unrll = dispatching_q && (remain_q == 7'd0);
   assign stll_ftch  = dispatching_q && (stall_cnt_q >= 7'(`LBD_BUF_SLOTS));

   assign stall_sum = {1'b0, stall_cnt_q} + valid_lanes;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         dispatching_q <= 1'b0;
         remain_q      <= '0;
         stall_cnt_q   <= '0;
      end else if (!dispatching_q) begin
         if (loop_strt) begin
            dispatching_q <= 1'b1;
            remain_q      <= hit_entry.max_unroll;
            stall_cnt_q   <= '0;
         end
      end else if (mis_pred_in) begin
         // flush back to fetch
         dispatching_q <= 1'b0;
         remain_q      <= '0;
         stall_cnt_q   <= '0;
      end else begin
         if (end_found && remain_q != 7'd0) begin
            remain_q <= remain_q - 1'b1;
         end
         stall_cnt_q <= stall_sum[7] ? 7'h7f : stall_sum[6:0];
      end
   end

   always_ff @(posedge clk) begin
      if (loop_strt) begin
         fallthru_q <= hit_entry.fallthrough_addr;
      end
   end

   a_no_strt_in_disp: assert property (@(posedge clk) disable iff (rst)
      disp_active |-> !loop_strt);

endmodule

// ==== verilog/lbd_top.sv ====
`timescale 1ns/10ps
`include "lbd_config.svh"

module lbd_top (
   input  logic                               clk,
   input  logic                               rst,
   input  logic [`LBD_LANES*`LBD_ADDR_W-1:0]  pc_in,
   input  fetch_pkg::bck_flags_t              bck_lp_bus_in,
   input  logic                               mis_pred_in,
   output logic                               loop_strt,
   output fetch_pkg::lane_mask_t              inst_valid,
   output logic                               fnsh_unrll,
   output logic                               stll_ftch,
   output lbd_pkg::lbd_state_t                lbd_state
);

   logic                train_busy;
   logic                train_wr;
   lbd_pkg::lat_entry_t train_entry;
   logic                lat_hit;
   lbd_pkg::lat_entry_t hit_entry;
   logic                disp_active;

   // producer: measures backward loops
   back_branch_trainer u_trainer (
      .clk           (clk),
      .rst           (rst),
      .pc_in         (pc_in),
      .bck_lp_bus_in (bck_lp_bus_in),
      .mis_pred_in   (mis_pred_in),
      .disp_active   (disp_active),
      .train_busy    (train_busy),
      .train_wr      (train_wr),
      .train_entry   (train_entry)
   );

   loop_addr_table u_lat (
      .clk         (clk),
      .rst         (rst),
      .pc_in       (pc_in),
      .train_wr    (train_wr),
      .train_entry (train_entry),
      .lat_hit     (lat_hit),
      .hit_entry   (hit_entry)
   );

   // consumer: replays hits out of the buffer
   unroll_dispatcher u_dispatch (
      .clk         (clk),
      .rst         (rst),
      .pc_in       (pc_in),
      .mis_pred_in (mis_pred_in),
      .lat_hit     (lat_hit),
      .hit_entry   (hit_entry),
      .train_busy  (train_busy),
      .disp_active (disp_active),
      .loop_strt   (loop_strt),
      .inst_valid  (inst_valid),
      .fnsh_unrll  (fnsh_unrll),
      .stll_ftch   (stll_ftch),
      .lbd_state   (lbd_state)
   );

endmodule

// ==== dv/lbd_ref_model.sv ====
`timescale 1ns/10ps
`include "lbd_config.svh"

module lbd_ref_model (
   input  logic                              clk,
   input  logic                              rst,
   input  logic [`LBD_LANES*`LBD_ADDR_W-1:0] pc,
   input  logic [`LBD_LANES-1:0]             flags,
   input  logic                              mis_pred,
   output logic                              exp_loop_strt,
   output logic [`LBD_LANES-1:0]             exp_inst_valid,
   output logic                              exp_fnsh_unrll,
   output logic                              exp_stll_ftch,
   output logic [1:0]                        exp_state
);

   localparam int LANES = `LBD_LANES;
   localparam int AW    = `LBD_ADDR_W;
   localparam int DEPTH = `LBD_LAT_DEPTH;
   localparam int BUF   = `LBD_BUF_SLOTS;

   int          tr_phase;  // 0 idle, 1 expecting the start bundle, 2 counting
   logic [15:0] tr_fall;
   logic [15:0] tr_start;
   int          tr_count;
   logic        wr_pend;   // entry goes into the table on the next edge
   logic        ent_valid [DEPTH];
   logic [15:0] ent_start [DEPTH];
   logic [15:0] ent_fall [DEPTH];
   int          ent_unroll [DEPTH];
   int          ptr;
   logic        in_disp;
   logic [15:0] d_fall;
   int          d_left;
   int          d_sum;
   int          hit;
   int          flag_lane;
   int          tr_end;
   int          d_end;

   function automatic logic [15:0] lane(input logic [LANES*AW-1:0] b, input int l);
      return b[(LANES-l)*AW-1 -: AW];
   endfunction

   // lowest lane holding the address, -1 if none
   function automatic int find_lane(input logic [LANES*AW-1:0] b, input logic [15:0] a);
      int r;
      r = -1;
      for (int l = LANES-1; l >= 0; l--)
         if (lane(b, l) == a)
            r = l;
      return r;
   endfunction

   always_comb begin
      hit = -1;
      for (int k = DEPTH-1; k >= 0; k--)
         if (ent_valid[k] && ent_start[k] == lane(pc, 0))
            hit = k;
      flag_lane = -1;
      for (int l = LANES-1; l >= 0; l--)
         if (flags[LANES-1-l])
            flag_lane = l;
      tr_end = find_lane(pc, tr_fall - 16'd1);
      d_end  = find_lane(pc, d_fall - 16'd1);
      exp_loop_strt  = (hit >= 0) && !in_disp;
      exp_inst_valid = '1;
      if (in_disp && d_end >= 0)
         for (int l = 0; l < LANES; l++)
            exp_inst_valid[LANES-1-l] = (l <= d_end);  // lanes past the branch dropped
      exp_fnsh_unrll = in_disp && (d_left == 0);
      exp_stll_ftch  = in_disp && (d_sum >= BUF);
      exp_state      = in_disp ? 2'd2 : ((tr_phase != 0) ? 2'd1 : 2'd0);
   end

   always_ff @(posedge clk or posedge rst) begin : model_step
      int cnt;
      if (rst) begin
         tr_phase <= 0;
         tr_count <= 0;
         wr_pend  <= 1'b0;
         ptr      <= 0;
         in_disp  <= 1'b0;
         d_left   <= 0;
         d_sum    <= 0;
         for (int k = 0; k < DEPTH; k++)
            ent_valid[k] <= 1'b0;
      end else begin
         wr_pend <= 1'b0;
         if (wr_pend) begin
            ent_valid[ptr]  <= 1'b1;
            ent_start[ptr]  <= tr_start;
            ent_fall[ptr]   <= tr_fall;
            ent_unroll[ptr] <= (tr_count > BUF) ? 0 : BUF / tr_count;
            ptr             <= (ptr + 1) % DEPTH;
         end
         if (tr_phase == 0) begin
            if (!in_disp && flag_lane >= 0) begin
               tr_phase <= 1;
               tr_fall  <= lane(pc, flag_lane) + 16'd1;
            end
         end else if (mis_pred || in_disp) begin
            tr_phase <= 0;  // training dropped
         end else begin
            cnt = (tr_phase == 1) ? 0 : tr_count;
            cnt = cnt + ((tr_end >= 0) ? tr_end + 1 : LANES);
            tr_count <= (cnt > 127) ? 127 : cnt;
            if (tr_phase == 1)
               tr_start <= lane(pc, 0);
            tr_phase <= (tr_end >= 0) ? 0 : 2;
            wr_pend  <= (tr_end >= 0);
         end
         if (!in_disp) begin
            if (hit >= 0) begin
               in_disp <= 1'b1;
               d_fall  <= ent_fall[hit];
               d_left  <= ent_unroll[hit];
               d_sum   <= 0;
            end
         end else if (mis_pred) begin
            in_disp <= 1'b0;
            d_left  <= 0;
            d_sum   <= 0;
         end else begin
            if (d_end >= 0 && d_left > 0)
               d_left <= d_left - 1;  // one pass used
            d_sum <= d_sum + ((d_end >= 0) ? d_end + 1 : LANES);
         end
      end
   end

endmodule

// ==== dv/lbd_tb.sv ====
`timescale 1ns/10ps
`include "lbd_config.svh"

module lbd_tb;

   localparam int LANES         = `LBD_LANES;
   localparam int AW            = `LBD_ADDR_W;
   localparam int BUF           = `LBD_BUF_SLOTS;
   localparam int RST_CYCLES    = 16;
   localparam int BODY_MAX      = 20;
   localparam int BODY_BUNDLES  = (BODY_MAX + LANES - 1) / LANES;
   localparam int TRAIN_BUNDLES = 2 * BODY_BUNDLES + 1;
   localparam int RUN_BUNDLES   = (BUF + 1) * BODY_BUNDLES;  // longest dispatch run
   localparam int TOTAL_BUNDLES = RST_CYCLES + 5 * TRAIN_BUNDLES + 3 * RUN_BUNDLES + 40;

   logic                  clk;
   logic                  rst;
   logic [LANES*AW-1:0]   pc_in;
   fetch_pkg::bck_flags_t bck_lp_bus_in;
   logic                  mis_pred_in;
   logic                  loop_strt;
   fetch_pkg::lane_mask_t inst_valid;
   logic                  fnsh_unrll;
   logic                  stll_ftch;
   lbd_pkg::lbd_state_t   lbd_state;
   logic                  exp_loop_strt;
   logic [LANES-1:0]      exp_inst_valid;
   logic                  exp_fnsh_unrll;
   logic                  exp_stll_ftch;
   logic [1:0]            exp_state;
   integer                seed;
   int                    err_count;
   int                    errs_at_start;
   int                    tests_failed;
   logic [15:0]           loop_start [5];
   int                    loop_len [5];

   lbd_top u_lbd_top (
      .clk(clk), .rst(rst), .pc_in(pc_in), .bck_lp_bus_in(bck_lp_bus_in),
      .mis_pred_in(mis_pred_in), .loop_strt(loop_strt), .inst_valid(inst_valid),
      .fnsh_unrll(fnsh_unrll), .stll_ftch(stll_ftch), .lbd_state(lbd_state)
   );

   lbd_ref_model u_model (
      .clk(clk), .rst(rst), .pc(pc_in), .flags(bck_lp_bus_in), .mis_pred(mis_pred_in),
      .exp_loop_strt(exp_loop_strt), .exp_inst_valid(exp_inst_valid),
      .exp_fnsh_unrll(exp_fnsh_unrll), .exp_stll_ftch(exp_stll_ftch), .exp_state(exp_state)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   initial begin
      #(TOTAL_BUNDLES * 10 + 500);
      $display("timeout: the run did not finish within %0d bundles", TOTAL_BUNDLES);
      $display("STATUS: FAIL");
      $finish;
   end

   task automatic flag_mismatch(input string name, input logic [15:0] exp, input logic [15:0] got);
      $display("ERROR %s exp=%h got=%h at %0t", name, exp, got, $time);
      err_count++;
   endtask

   // outputs are settled by the falling edge
   always @(negedge clk) begin
      if (!rst) begin
         if (loop_strt !== exp_loop_strt)
            flag_mismatch("loop_strt", exp_loop_strt, loop_strt);
         if (inst_valid !== exp_inst_valid)
            flag_mismatch("inst_valid", exp_inst_valid, inst_valid);
         if (fnsh_unrll !== exp_fnsh_unrll)
            flag_mismatch("fnsh_unrll", exp_fnsh_unrll, fnsh_unrll);
         if (stll_ftch !== exp_stll_ftch)
            flag_mismatch("stll_ftch", exp_stll_ftch, stll_ftch);
         if (lbd_state !== exp_state)
            flag_mismatch("lbd_state", exp_state, lbd_state);
      end
   end

   task automatic drive_bundle(input logic [15:0] base, input int flag_lane, input logic mp);
      @(posedge clk);
      #1;
      for (int l = 0; l < LANES; l++)
         pc_in[(LANES-l)*AW-1 -: AW] = base + 16'(l);
      bck_lp_bus_in = '0;
      if (flag_lane >= 0)
         bck_lp_bus_in[LANES-1-flag_lane] = 1'b1;
      mis_pred_in = mp;
   endtask

   // the branch flag sits on the last bundle of the body
   task automatic drive_body(input int n, input int k, input logic mp);
      int last;
      last = (loop_len[n] - 1) / LANES;
      drive_bundle(loop_start[n] + 16'(LANES * k),
                   (k == last) ? (loop_len[n] - 1) % LANES : -1, mp);
   endtask

   task automatic drive_idle(input logic mp);
      drive_bundle(16'hc000 + 16'({$random(seed)} % 1024) * 16'd4, -1, mp);
   endtask

   task automatic fetch_pass(input int n);
      for (int k = 0; k <= (loop_len[n] - 1) / LANES; k++)
         drive_body(n, k, 1'b0);
   endtask

   // flagged pass starts training, second pass is measured
   task automatic train_loop(input int n);
      loop_len[n]   = 1 + {$random(seed)} % BODY_MAX;
      loop_start[n] = 16'h0400 * 16'(n + 1) + 16'({$random(seed)} % 16) * 16'd64;
      fetch_pass(n);
      fetch_pass(n);
      drive_idle(1'b0);  // table write cycle
   endtask

   task automatic probe_start(input int n, output logic seen);
      drive_body(n, 0, 1'b0);
      @(negedge clk);
      seen = loop_strt;
   endtask

   task automatic finish_test(input int num, input string name);
      if (err_count == errs_at_start) begin
         $display("test %0d %s: ok", num, name);
      end else begin
         tests_failed++;
         $display("test %0d %s: %0d errors", num, name, err_count - errs_at_start);
      end
      errs_at_start = err_count;
   endtask

   initial begin : main_seq
      logic seen;
      int   nb;
      int   k;
      int   steps;
      int   ends;
      int   lanes_sum;
      logic got;
      seed          = 32'haa98_4825;
      err_count     = 0;
      errs_at_start = 0;
      tests_failed  = 0;
      rst           = 1'b1;
      pc_in         = {LANES{16'hc000}};
      bck_lp_bus_in = '0;
      mis_pred_in   = 1'b0;
      repeat (RST_CYCLES) @(posedge clk);
      #1;
      rst = 1'b0;

      @(negedge clk);
      if (loop_strt !== 1'b0)
         flag_mismatch("loop_strt", 1'b0, loop_strt);
      if (inst_valid !== 4'hf)
         flag_mismatch("inst_valid", 4'hf, inst_valid);
      if (fnsh_unrll !== 1'b0)
         flag_mismatch("fnsh_unrll", 1'b0, fnsh_unrll);
      if (stll_ftch !== 1'b0)
         flag_mismatch("stll_ftch", 1'b0, stll_ftch);
      if (lbd_state !== lbd_pkg::IDLE)
         flag_mismatch("lbd_state", lbd_pkg::IDLE, lbd_state);
      finish_test(1, "reset values");

      train_loop(0);
      probe_start(0, seen);
      if (seen !== 1'b1)
         flag_mismatch("loop_strt", 1'b1, seen);
      for (k = 1; k <= (loop_len[0] - 1) / LANES; k++)
         drive_body(0, k, 1'b0);
      fetch_pass(0);  // masks checked against the model
      drive_idle(1'b1);
      finish_test(2, "train then hit");

      train_loop(1);
      nb = (loop_len[1] - 1) / LANES + 1;
      probe_start(1, seen);
      ends  = 0;
      got   = 1'b0;
      steps = 0;
      k     = 1 % nb;
      while (!got && steps < RUN_BUNDLES) begin
         drive_body(1, k, 1'b0);
         @(negedge clk);
         got = (fnsh_unrll === 1'b1);
         if (!got && k == nb - 1)
            ends++;
         k = (k + 1) % nb;
         steps++;
      end
      if (!got) begin
         $display("fnsh_unrll never rose during the unroll countdown");
         err_count++;
      end else if (ends != BUF / loop_len[1]) begin
         flag_mismatch("fnsh_unrll passes", BUF / loop_len[1], ends);
      end
      finish_test(3, "unroll countdown");

      drive_idle(1'b1);
      drive_idle(1'b0);
      @(negedge clk);
      if (lbd_state !== lbd_pkg::IDLE)
         flag_mismatch("lbd_state", lbd_pkg::IDLE, lbd_state);
      probe_start(1, seen);
      if (seen !== 1'b1)
         flag_mismatch("loop_strt", 1'b1, seen);
      drive_idle(1'b1);
      finish_test(4, "misprediction");

      for (int n = 2; n < 5; n++)
         train_loop(n);
      for (int n = 0; n < 5; n++) begin
         probe_start(n, seen);
         if (seen !== (n != 0))  // entry 0 now holds loop 4
            flag_mismatch("loop_strt", n != 0, seen);
         drive_idle(1'b1);
      end
      finish_test(5, "replacement");

      probe_start(1, seen);
      lanes_sum = 0;
      got       = 1'b0;
      steps     = 0;
      k         = 1 % nb;
      while (!got && steps < RUN_BUNDLES) begin
         drive_body(1, k, 1'b0);
         @(negedge clk);
         if (stll_ftch !== (lanes_sum >= BUF))
            flag_mismatch("stll_ftch", lanes_sum >= BUF, stll_ftch);
         got = (stll_ftch === 1'b1);
         lanes_sum += (k == nb - 1) ? (loop_len[1] - 1) % LANES + 1 : LANES;
         k = (k + 1) % nb;
         steps++;
      end
      if (!got) begin
         $display("stll_ftch never rose while the buffer filled");
         err_count++;
      end
      drive_idle(1'b1);
      drive_idle(1'b0);
      @(negedge clk);
      finish_test(6, "fetch stall");

      $display("tests 6, failed %0d, errors %0d", tests_failed, err_count);
      if (err_count == 0) begin
         $display("STATUS: PASS");
      end else begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

endmodule

// ==== build.f ====
+incdir+common
common/fetch_pkg.sv
common/lbd_pkg.sv
trainer/back_branch_trainer.sv
verilog/loop_addr_table.sv
dispatch/unroll_dispatcher.sv
verilog/lbd_top.sv
dv/lbd_ref_model.sv
dv/lbd_tb.sv
